/* dv/rep_store_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the repetition-coded store
// Random host traffic and fault injection against a block model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module rep_store_tb;

  import rep_store_pkg::*;

  localparam int DW       = DEF_DATA_WIDTH;
  localparam int REP      = DEF_REPETITION;
  localparam int DEPTH    = DEF_DEPTH;
  localparam int INTERVAL = DEF_SCRUB_INTERVAL;
  localparam int AW       = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int BW       = REP * DW;

  localparam int N_WRITES       = 32;
  localparam int N_DENSE        = 400;
  localparam int N_SCRUB_FAULTS = 6;

  // Planned cycles per test
  localparam int LEN_T1 = N_WRITES + DEPTH + 10;
  localparam int LEN_T2 = BW * 4 + 10;
  localparam int LEN_T3 = DW * 4 + 10;
  localparam int LEN_T4 = 2 * DEPTH * INTERVAL + 2 * DEPTH + N_SCRUB_FAULTS + 20;
  localparam int LEN_T5 = N_DENSE + 10;
  localparam int CYCLE_LIMIT = 2 * (5 + LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5);

  logic clk;
  logic rst;
  logic host_wr;
  logic host_rd;
  logic [AW-1:0] host_addr;
  logic [DW-1:0] host_wdata;
  logic rd_valid;
  logic [DW-1:0] rd_data;
  logic rd_error;
  logic fault_en;
  logic [AW-1:0] fault_addr;
  logic [BW-1:0] fault_mask;
  repair_count_t repair_count;
  logic scrub_busy;

  // Model state
  logic [BW-1:0] model [DEPTH];
  int            due_q[$];
  logic [DW-1:0] data_q[$];
  logic          err_q[$];

  // Model scrub walk, moves on each finished scrub step
  logic [AW-1:0] scrub_ptr = '0;
  logic          busy_prev = 1'b0;
  repair_count_t count_prev = '0;

  int cyc = 0;
  int seed = 26216;
  int test_errors = 0;
  int total_errors = 0;
  int n_checks = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  rep_store_top rep_store_top_i (
    .clk          (clk),
    .rst          (rst),
    .host_wr      (host_wr),
    .host_rd      (host_rd),
    .host_addr    (host_addr),
    .host_wdata   (host_wdata),
    .rd_valid     (rd_valid),
    .rd_data      (rd_data),
    .rd_error     (rd_error),
    .fault_en     (fault_en),
    .fault_addr   (fault_addr),
    .fault_mask   (fault_mask),
    .repair_count (repair_count),
    .scrub_busy   (scrub_busy)
  );

  always #10 clk = ~clk;

  // Bit-wise majority over the copies
  function automatic logic [DW-1:0] vote(input logic [BW-1:0] blk);
    int ones;
    logic [DW-1:0] w;
    for (int b = 0; b < DW; b++) begin
      ones = 0;
      for (int r = 0; r < REP; r++) begin
        ones += blk[r*DW + b];
      end
      w[b] = (2 * ones > REP);
    end
    return w;
  endfunction

  // Any copy differing from copy 0
  function automatic logic disagree(input logic [BW-1:0] blk);
    logic d;
    d = 1'b0;
    for (int r = 1; r < REP; r++) begin
      d |= (blk[r*DW +: DW] != blk[DW-1:0]);
    end
    return d;
  endfunction

  function automatic logic [AW-1:0] pick_addr();
    return AW'($unsigned($random(seed)) % DEPTH);
  endfunction

  function automatic logic [DW-1:0] pick_word();
    return DW'($random(seed));
  endfunction

  // Random nonzero flips confined to one copy
  function automatic logic [BW-1:0] single_copy_mask();
    int copy;
    logic [DW-1:0] bits;
    logic [BW-1:0] m;
    copy = $unsigned($random(seed)) % REP;
    bits = pick_word();
    if (bits == '0) begin
      bits = 1;
    end
    m = '0;
    m[copy*DW +: DW] = bits;
    return m;
  endfunction

  task automatic note_error();
    test_errors++;
    total_errors++;
  endtask

  // A step ends when scrub_busy drops, a repair when repair_count moves
  task automatic track_scrub();
    logic stepped;
    logic repaired;
    stepped  = busy_prev && !scrub_busy;
    repaired = (repair_count != count_prev);
    assert (!repaired || (stepped && repair_count == count_prev + 1'b1)) else begin
      $display("Error at %0t: repair_count moved without one finished scrub step", $time);
      note_error();
    end
    if (repaired) begin
      assert (disagree(model[scrub_ptr])) else begin
        $display("Error at %0t: scrubber repaired block %0d which held no fault", $time,
                 scrub_ptr);
        note_error();
      end
      // Write back of fresh copies at the walk address
      model[scrub_ptr] = {REP{vote(model[scrub_ptr])}};
    end
    if (stepped) begin
      if (scrub_ptr == AW'(DEPTH - 1)) begin
        scrub_ptr = '0;
      end else begin
        scrub_ptr = scrub_ptr + 1'b1;
      end
    end
    busy_prev  = scrub_busy;
    count_prev = repair_count;
  endtask

  // Compare the read port against the oldest expected read
  task automatic check_read_port();
    if (due_q.size() != 0 && due_q[0] == cyc) begin
      n_checks++;
      assert (rd_valid === 1'b1) else begin
        $display("Error at %0t: rd_valid missing two cycles after a read", $time);
        note_error();
      end
      if (rd_valid === 1'b1) begin
        assert (rd_data === data_q[0]) else begin
          $display("Mismatch at %0t: rd_data %h, expected %h", $time, rd_data, data_q[0]);
          note_error();
        end
        assert (rd_error === err_q[0]) else begin
          $display("Mismatch at %0t: rd_error %b, expected %b", $time, rd_error, err_q[0]);
          note_error();
        end
      end
      void'(due_q.pop_front());
      void'(data_q.pop_front());
      void'(err_q.pop_front());
    end else begin
      assert (rd_valid !== 1'b1) else begin
        $display("Error at %0t: rd_valid pulsed with no read due", $time);
        note_error();
      end
    end
  endtask

  // Inputs seen here are sampled at the next edge
  task automatic model_update();
    if (host_rd && !host_wr) begin
      due_q.push_back(cyc + 2);
      data_q.push_back(vote(model[host_addr]));
      err_q.push_back(disagree(model[host_addr]));
    end
    if (host_wr) begin
      model[host_addr] = {REP{host_wdata}};
    end
    // Write to the same block drops the fault
    if (fault_en && !(host_wr && host_addr == fault_addr)) begin
      model[fault_addr] = model[fault_addr] ^ fault_mask;
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      track_scrub();
      check_read_port();
      model_update();
    end
  end

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > CYCLE_LIMIT) begin
      $display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic drive(input logic wr, input logic rd, input logic [AW-1:0] addr,
                       input logic [DW-1:0] wdata, input logic fen,
                       input logic [AW-1:0] faddr, input logic [BW-1:0] fmask);
    @(posedge clk);
    host_wr    <= wr;
    host_rd    <= rd;
    host_addr  <= addr;
    host_wdata <= wdata;
    fault_en   <= fen;
    fault_addr <= faddr;
    fault_mask <= fmask;
  endtask

  task automatic idle();
    drive(1'b0, 1'b0, '0, '0, 1'b0, '0, '0);
  endtask

  // Last read is queued one falling edge after its drive
  task automatic drain_reads();
    idle();
    while (due_q.size() != 0) begin
      idle();
    end
  endtask

  task automatic read_all();
    for (int a = 0; a < DEPTH; a++) begin
      drive(1'b0, 1'b1, AW'(a), '0, 1'b0, '0, '0);
    end
    drain_reads();
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("Test %s: %s, %0d errors", name, (test_errors == 0) ? "PASS" : "FAIL",
             test_errors);
    test_errors = 0;
  endtask

  initial begin
    logic [AW-1:0] a;
    logic [AW-1:0] fa;
    logic [AW-1:0] last_fa;
    logic [BW-1:0] fm;
    logic          fen;
    logic          last_fen;
    int            kind;
    int            n_faults;
    repair_count_t count_before;
    repair_count_t count_after;

    clk        = 1'b0;
    rst        = 1'b1;
    host_wr    = 1'b0;
    host_rd    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    fault_en   = 1'b0;
    fault_addr = '0;
    fault_mask = '0;
    for (int i = 0; i < DEPTH; i++) begin
      model[i] = '0;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Reset state, then random writes and a full readback
    @(negedge clk);
    assert (rd_valid === 1'b0 && scrub_busy === 1'b0 && repair_count === '0) else begin
      $display("Error at %0t: outputs not cleared by reset", $time);
      note_error();
    end
    for (int i = 0; i < N_WRITES; i++) begin
      drive(1'b1, 1'b0, pick_addr(), pick_word(), 1'b0, '0, '0);
    end
    read_all();
    finish_test("write_read");

    // One flipped bit per block position, vote restores it
    for (int p = 0; p < BW; p++) begin
      a = pick_addr();
      drive(1'b1, 1'b0, a, pick_word(), 1'b0, '0, '0);
      drive(1'b0, 1'b0, '0, '0, 1'b1, a, BW'(1) << p);
      drive(1'b0, 1'b1, a, '0, 1'b0, '0, '0);
    end
    drain_reads();
    finish_test("single_copy_fault");

    // Majority of copies flipped, flipped bit wins
    for (int b = 0; b < DW; b++) begin
      a = pick_addr();
      fm = '0;
      for (int r = 0; r <= REP / 2; r++) begin
        fm[r*DW + b] = 1'b1;
      end
      drive(1'b1, 1'b0, a, pick_word(), 1'b0, '0, '0);
      drive(1'b0, 1'b0, '0, '0, 1'b1, a, fm);
      drive(1'b0, 1'b1, a, '0, 1'b0, '0, '0);
    end
    drain_reads();
    finish_test("majority_fault");

    // Clean slate, faults, then a long idle for the scrubber
    for (int i = 0; i < DEPTH; i++) begin
      drive(1'b1, 1'b0, AW'(i), pick_word(), 1'b0, '0, '0);
    end
    idle();
    @(negedge clk);
    count_before = repair_count;
    a = pick_addr();
    // Odd stride keeps the addresses distinct
    for (int i = 0; i < N_SCRUB_FAULTS; i++) begin
      fa = AW'((a + i * 3) % DEPTH);
      drive(1'b0, 1'b0, '0, '0, 1'b1, fa, single_copy_mask());
    end
    repeat (2 * DEPTH * INTERVAL) idle();
    @(negedge clk);
    count_after = repair_count;
    assert (int'(count_after - count_before) == N_SCRUB_FAULTS) else begin
      $display("Mismatch at %0t: repair_count grew by %0d, expected %0d", $time,
               int'(count_after - count_before), N_SCRUB_FAULTS);
      note_error();
    end
    // Every faulty block must have been written back by now
    for (int i = 0; i < DEPTH; i++) begin
      assert (!disagree(model[i])) else begin
        $display("Error at %0t: block %0d still faulty after the scrub wait", $time, i);
        note_error();
      end
    end
    read_all();
    finish_test("scrub_repair");

    // Dense mixed traffic with the scrubber running
    n_faults = 0;
    last_fen = 1'b0;
    last_fa = '0;
    @(negedge clk);
    count_before = repair_count;
    for (int i = 0; i < N_DENSE; i++) begin
      kind = $unsigned($random(seed)) % 20;
      a = pick_addr();
      fa = pick_addr();
      fm = '0;
      fen = 1'b0;
      // Fault only blocks the model holds clean
      if (($unsigned($random(seed)) % 6 == 0) && !disagree(model[fa]) &&
          !(last_fen && last_fa == fa)) begin
        fen = 1'b1;
        fm = single_copy_mask();
        n_faults++;
      end
      drive((kind < 6) || (kind == 19), ((kind >= 6) && (kind < 13)) || (kind == 19),
            a, pick_word(), fen, fa, fm);
      last_fen = fen;
      last_fa = fa;
    end
    drain_reads();
    @(negedge clk);
    count_after = repair_count;
    assert (int'(count_after - count_before) <= n_faults) else begin
      $display("Error at %0t: scrubber repaired more blocks than were faulted", $time);
      note_error();
    end
    finish_test("dense_random");

    $display("Tests: %0d passed, %0d failed, %0d reads checked, %0d errors",
             tests_passed, tests_failed, n_checks, total_errors);
    if (tests_failed == 0 && total_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
logic/rep_store_pkg.sv
logic/store_port_if.sv
logic/repetition_block_corrector.sv
logic/rep_block_store.sv
logic/scrub_timer.sv
logic/scrub_sequencer.sv
logic/rep_store_top.sv
dv/rep_store_tb.sv

/* logic/rep_block_store.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register array of coded blocks behind one access port
// Writes replicate the word, reads return the raw block
// Fault port flips stored bits to exercise the corrector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module rep_block_store #(
  parameter int DATA_WIDTH = 8,
  parameter int REPETITION = 3,
  parameter int DEPTH      = 16,
  localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input wire                           clk,
  input wire                           rst,

  store_port_if.store                  port,

  input wire                           fault_en,
  input wire [ADDR_WIDTH-1:0]          fault_addr,
  input wire [REPETITION*DATA_WIDTH-1:0] fault_mask
);

  localparam int BLOCK_WIDTH = REPETITION * DATA_WIDTH;

  // Coded blocks, REPETITION copies each
  logic [BLOCK_WIDTH-1:0] mem [DEPTH];

  // Port write this cycle
  logic port_wr;
  // Write lands on the faulted block, fault is dropped
  logic fault_blocked;

  assign port_wr       = port.en && port.we;
  assign fault_blocked = port_wr && (port.addr == fault_addr);

  // Array update
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else begin
      // Fresh copies of the word
      if (port_wr) begin
        mem[port.addr] <= {REPETITION{port.wdata}};
      end
      // XOR the mask into the stored copies
      if (fault_en && !fault_blocked) begin
        mem[fault_addr] <= mem[fault_addr] ^ fault_mask;
      end
    end
  end

  // Registered read, block held between reads
  always_ff @(posedge clk) begin
    if (port.en && !port.we) begin
      port.rblock <= mem[port.addr];
    end
  end

endmodule

`default_nettype wire

/* logic/rep_store_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Defaults and shared types for the repetition-coded store
// Top level reads the defaults, the scrubber uses the types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rep_store_pkg;

  // Bits per data word
  parameter int DEF_DATA_WIDTH = 8;

  // Copies kept per word, odd so a vote never ties
  parameter int DEF_REPETITION = 3;

  // Words in the store
  parameter int DEF_DEPTH = 16;

  // Cycles between two scrub steps
  parameter int DEF_SCRUB_INTERVAL = 64;

  // Repairs done by the scrubber, sticks at all ones
  typedef logic [15:0] repair_count_t;

  // Scrub walk, one block per pass
  typedef enum logic [1:0] {
    SCRUB_IDLE,
    SCRUB_READ,
    SCRUB_CHECK,
    SCRUB_FIX
  } scrub_state_t;

endpackage

`default_nettype wire

/* logic/rep_store_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-correcting repetition-coded word store
// Host reads and writes words, a background scrubber repairs blocks
// Host always wins the single store port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module rep_store_top #(
  parameter int DATA_WIDTH     = rep_store_pkg::DEF_DATA_WIDTH,
  parameter int REPETITION     = rep_store_pkg::DEF_REPETITION,
  parameter int DEPTH          = rep_store_pkg::DEF_DEPTH,
  parameter int SCRUB_INTERVAL = rep_store_pkg::DEF_SCRUB_INTERVAL,
  localparam int ADDR_WIDTH    = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  wire                            clk,
  input  wire                            rst,

  // Host access
  input  wire                            host_wr,
  input  wire                            host_rd,
  input  wire [ADDR_WIDTH-1:0]           host_addr,
  input  wire [DATA_WIDTH-1:0]           host_wdata,

  // Read result, two cycles after the read
  output logic                           rd_valid,
  output logic [DATA_WIDTH-1:0]          rd_data,
  output logic                           rd_error,

  // Fault injection
  input  wire                            fault_en,
  input  wire [ADDR_WIDTH-1:0]           fault_addr,
  input  wire [REPETITION*DATA_WIDTH-1:0] fault_mask,

  // Scrub status
  output rep_store_pkg::repair_count_t   repair_count,
  output logic                           scrub_busy
);

  // Host owns the port this cycle
  logic host_access;
  // Host write aimed at the block under scrub
  logic host_wr_hit;
  // Store read in flight for the host
  logic host_rd_q;

  // Scrubber side
  logic                  scrub_req;
  logic                  scrub_req_we;
  logic                  scrub_granted;
  logic                  scrub_tick;
  logic                  scrub_step;
  logic [ADDR_WIDTH-1:0] scrub_addr;
  logic [DATA_WIDTH-1:0] scrub_fix_data;

  // Corrector output, shared by host and scrubber
  logic [DATA_WIDTH-1:0] corrected_data;
  logic                  corrected_error;

  store_port_if #(
    .DATA_WIDTH (DATA_WIDTH),
    .REPETITION (REPETITION),
    .DEPTH      (DEPTH)
  ) store_port ();

  assign host_access   = host_wr || host_rd;
  assign host_wr_hit   = host_wr && (host_addr == scrub_addr);
  assign scrub_granted = scrub_req && !host_access;

  // Arbiter, master side of the port
  // Write wins when the host asserts both
  assign store_port.en    = host_access || scrub_req;
  assign store_port.we    = host_access ? host_wr : scrub_req_we;
  assign store_port.addr  = host_access ? host_addr : scrub_addr;
  assign store_port.wdata = host_access ? host_wdata : scrub_fix_data;

  rep_block_store #(
    .DATA_WIDTH (DATA_WIDTH),
    .REPETITION (REPETITION),
    .DEPTH      (DEPTH)
  ) rep_block_store_i (
    .clk        (clk),
    .rst        (rst),
    .port       (store_port.store),
    .fault_en   (fault_en),
    .fault_addr (fault_addr),
    .fault_mask (fault_mask)
  );

  repetition_block_corrector #(
    .DATA_WIDTH (DATA_WIDTH),
    .REPETITION (REPETITION)
  ) repetition_block_corrector_i (
    .block          (store_port.rblock),
    .corrected_data (corrected_data),
    .error          (corrected_error)
  );

  scrub_timer #(
    .DEPTH          (DEPTH),
    .SCRUB_INTERVAL (SCRUB_INTERVAL)
  ) scrub_timer_i (
    .clk        (clk),
    .rst        (rst),
    .step       (scrub_step),
    .tick       (scrub_tick),
    .scrub_addr (scrub_addr)
  );

  scrub_sequencer #(
    .DATA_WIDTH (DATA_WIDTH)
  ) scrub_sequencer_i (
    .clk          (clk),
    .rst          (rst),
    .tick         (scrub_tick),
    .granted      (scrub_granted),
    .host_access  (host_access),
    .host_wr_hit  (host_wr_hit),
    .check_error  (corrected_error),
    .check_data   (corrected_data),
    .req          (scrub_req),
    .req_we       (scrub_req_we),
    .fix_data     (scrub_fix_data),
    .step         (scrub_step),
    .scrub_busy   (scrub_busy),
    .repair_count (repair_count)
  );

  // Read pipeline flag, a host read that lost to its own write is dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      host_rd_q <= 1'b0;
      rd_valid  <= 1'b0;
    end else begin
      host_rd_q <= host_rd && !host_wr;
      rd_valid  <= host_rd_q;
    end
  end

  // Output register, loads only for host reads
  always_ff @(posedge clk) begin
    if (host_rd_q) begin
      rd_data  <= corrected_data;
      rd_error <= corrected_error;
    end
  end

endmodule

`default_nettype wire

/* logic/repetition_block_corrector.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit-wise majority vote over the copies of one coded block
// Purely combinational, sits between store read and users
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module repetition_block_corrector #(
  parameter int DATA_WIDTH = 8,
  parameter int REPETITION = 3
) (
  input  wire  [REPETITION*DATA_WIDTH-1:0] block,
  output logic [DATA_WIDTH-1:0]            corrected_data,
  output logic                             error
);

  // Enough bits to count every copy set
  localparam int COUNT_WIDTH = $clog2(REPETITION + 1);

  // One flag per bit position where copies differ
  logic [DATA_WIDTH-1:0] disagree;

  for (genvar b = 0; b < DATA_WIDTH; b++) begin : gen_bit
    // Bit b taken from every copy
    logic [REPETITION-1:0]  copies;
    logic [COUNT_WIDTH-1:0] ones_count;

    // Copy r lives at offset r*DATA_WIDTH
    for (genvar r = 0; r < REPETITION; r++) begin : gen_copy
      assign copies[r] = block[r*DATA_WIDTH + b];
    end

    // Ones count of the gathered bits
    always_comb begin
      ones_count = '0;
      for (int r = 0; r < REPETITION; r++) begin
        ones_count = ones_count + COUNT_WIDTH'(copies[r]);
      end
    end

    // More than half the copies decide the bit
    assign corrected_data[b] = (ones_count > COUNT_WIDTH'(REPETITION / 2));

    // Mixed ones and zeros means some copy was hit
    assign disagree[b] = ~((&copies) | ~(|copies));
  end

  // Any bit position in conflict
  assign error = |disagree;

endmodule

`default_nettype wire

/* logic/scrub_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scrub FSM: read a block, check it, write back the corrected word
// Always yields the port to the host and retries
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module scrub_sequencer #(
  parameter int DATA_WIDTH = 8
) (
  input  wire                         clk,
  input  wire                         rst,

  input  wire                         tick,
  input  wire                         granted,

  input  wire                         host_access,
  input  wire                         host_wr_hit,

  input  wire                         check_error,
  input  wire [DATA_WIDTH-1:0]        check_data,

  output logic                        req,
  output logic                        req_we,
  output logic [DATA_WIDTH-1:0]       fix_data,
  output logic                        step,
  output logic                        scrub_busy,
  output rep_store_pkg::repair_count_t repair_count
);

  import rep_store_pkg::*;

  scrub_state_t state;
  scrub_state_t state_next;

  // Block finished, clean or repaired
  logic check_clean;
  logic fix_done;

  // Checked block clean, host left the port alone
  assign check_clean = (state == SCRUB_CHECK) && !host_access && !check_error;

  // Write back went through
  assign fix_done = (state == SCRUB_FIX) && !host_wr_hit && granted;

  // Port request, write only when fixing
  assign req    = (state == SCRUB_READ) || (state == SCRUB_FIX);
  assign req_we = (state == SCRUB_FIX);

  // Advance the walk pointer
  assign step = check_clean || fix_done;

  assign scrub_busy = (state != SCRUB_IDLE);

  // Next state
  always_comb begin
    state_next = state;
    case (state)
      SCRUB_IDLE: begin
        // Ticks only count while idle
        if (tick) begin
          state_next = SCRUB_READ;
        end
      end
      SCRUB_READ: begin
        if (granted) begin
          state_next = SCRUB_CHECK;
        end
      end
      SCRUB_CHECK: begin
        // Host touched the port, sample may be stale
        if (host_access) begin
          state_next = SCRUB_READ;
        end else if (check_error) begin
          state_next = SCRUB_FIX;
        end else begin
          state_next = SCRUB_IDLE;
        end
      end
      SCRUB_FIX: begin
        // Host rewrote our block, latched word is old
        if (host_wr_hit) begin
          state_next = SCRUB_READ;
        end else if (granted) begin
          state_next = SCRUB_IDLE;
        end
      end
      default: begin
        state_next = SCRUB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SCRUB_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Corrected word held for the write back
  always_ff @(posedge clk) begin
    if ((state == SCRUB_CHECK) && (state_next == SCRUB_FIX)) begin
      fix_data <= check_data;
    end
  end

  // Repair counter, saturates
  always_ff @(posedge clk) begin
    if (rst) begin
      repair_count <= '0;
    end else if (fix_done && (repair_count != '1)) begin
      repair_count <= repair_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/scrub_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Paces the background scrub
// Interval tick to start a step, address pointer moved on step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module scrub_timer #(
  parameter int DEPTH          = 16,
  parameter int SCRUB_INTERVAL = 64,
  localparam int ADDR_WIDTH    = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   step,
  output logic                  tick,
  output logic [ADDR_WIDTH-1:0] scrub_addr
);

  localparam int INTERVAL_WIDTH = (SCRUB_INTERVAL > 1) ? $clog2(SCRUB_INTERVAL) : 1;

  // Cycles since the last tick
  logic [INTERVAL_WIDTH-1:0] interval_cnt;
  logic                      interval_done;

  assign interval_done = (interval_cnt == INTERVAL_WIDTH'(SCRUB_INTERVAL - 1));

  // Free running interval, one tick per wrap
  always_ff @(posedge clk) begin
    if (rst) begin
      interval_cnt <= '0;
      tick         <= 1'b0;
    end else if (interval_done) begin
      interval_cnt <= '0;
      tick         <= 1'b1;
    end else begin
      interval_cnt <= interval_cnt + 1'b1;
      tick         <= 1'b0;
    end
  end

  // Walk pointer, only moves when a step completes
  always_ff @(posedge clk) begin
    if (rst) begin
      scrub_addr <= '0;
    end else if (step) begin
      // Wrap at DEPTH, which need not be a power of two
      if (scrub_addr == ADDR_WIDTH'(DEPTH - 1)) begin
        scrub_addr <= '0;
      end else begin
        scrub_addr <= scrub_addr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/store_port_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single access port of the coded block store
// Arbiter side drives the request, store side returns the block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

interface store_port_if #(
  parameter int DATA_WIDTH = 8,
  parameter int REPETITION = 3,
  parameter int DEPTH      = 16,
  localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1
);

  // Access this cycle, write when we is high
  logic                           en;
  logic                           we;
  logic [ADDR_WIDTH-1:0]          addr;
  // One word, replicated by the store
  logic [DATA_WIDTH-1:0]          wdata;
  // Whole coded block, one cycle after the read
  logic [REPETITION*DATA_WIDTH-1:0] rblock;

  modport master (output en, output we, output addr, output wdata, input rblock);

  modport store (input en, input we, input addr, input wdata, output rblock);

endinterface

`default_nettype wire
